// ==== aes_encrypt.f ====
+incdir+.
aes_types_pkg.sv
aes_math_pkg.sv
aes_key_expand.sv
aes_round.sv
aes_pipe_stage.sv
aes_stage_ctrl.sv
aes_encrypt.sv
tb_aes_encrypt.sv

// ==== Makefile ====
LOG = sim.log

sim:
	verilator --binary -j 0 --timescale 1ns/1ps --top-module tb_aes_encrypt \
		-f aes_encrypt.f -o tb_aes_encrypt
	./obj_dir/tb_aes_encrypt | tee $(LOG)
	grep -q "Finished with no errors" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

.PHONY: sim clean

// ==== aes_ref_model.svh ====
`ifndef AES_REF_MODEL_SVH
`define AES_REF_MODEL_SVH

//////////////////////////////
// Random source
//////////////////////////////

// 32-bit Galois LFSR with taps 32 22 2 1
function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
endfunction

//////////////////////////////
// Software AES-128
//////////////////////////////

aes_types_pkg::aes_byte_t sbox_table [0:255];

function automatic aes_types_pkg::aes_byte_t times_two(input aes_types_pkg::aes_byte_t a);
    return a[7] ? ((a << 1) ^ 8'h1b) : (a << 1);
endfunction

// Horner form with the msb of b first
function automatic aes_types_pkg::aes_byte_t field_mul(
    input aes_types_pkg::aes_byte_t a,
    input aes_types_pkg::aes_byte_t b
);
    aes_types_pkg::aes_byte_t p;
    p = 8'h00;
    for (int i = 7; i >= 0; i--) begin
        p = times_two(p);
        if (b[i]) begin
            p = p ^ a;
        end
    end
    return p;
endfunction

// Inverse by search and then the affine map
task automatic build_sbox_table();
    aes_types_pkg::aes_byte_t inv;
    aes_types_pkg::aes_byte_t s;
    aes_types_pkg::aes_byte_t affine_c;
    affine_c = 8'h63;
    for (int x = 0; x < 256; x++) begin
        inv = 8'h00;
        for (int y = 1; y < 256; y++) begin
            if (field_mul(x[7:0], y[7:0]) == 8'h01) begin
                inv = y[7:0];
            end
        end
        for (int i = 0; i < 8; i++) begin
            s[i] = inv[i] ^ inv[(i + 4) % 8] ^ inv[(i + 5) % 8] ^ inv[(i + 6) % 8] ^
                   inv[(i + 7) % 8] ^ affine_c[i];
        end
        sbox_table[x] = s;
    end
endtask

function automatic aes_types_pkg::aes_block_u encrypt_model(
    input aes_types_pkg::aes_block_u plain,
    input aes_types_pkg::aes_block_u cipher_key
);
    aes_types_pkg::aes_byte_t st [0:15];
    aes_types_pkg::aes_byte_t tmp [0:15];
    aes_types_pkg::aes_byte_t rk [0:175];
    aes_types_pkg::aes_byte_t rcon;
    aes_types_pkg::aes_byte_t t0;
    aes_types_pkg::aes_byte_t t1;
    aes_types_pkg::aes_byte_t t2;
    aes_types_pkg::aes_byte_t t3;
    aes_types_pkg::aes_block_u result;
    for (int i = 0; i < 16; i++) begin
        rk[i] = cipher_key.bytes[i];
    end
    // Key schedule builds one word per pass
    rcon = 8'h01;
    for (int i = 16; i < 176; i += 4) begin
        t0 = rk[i - 4];
        t1 = rk[i - 3];
        t2 = rk[i - 2];
        t3 = rk[i - 1];
        if (i % 16 == 0) begin
            {t0, t1, t2, t3} = {sbox_table[t1] ^ rcon, sbox_table[t2],
                                sbox_table[t3], sbox_table[t0]};
            rcon = times_two(rcon);
        end
        rk[i] = rk[i - 16] ^ t0;
        rk[i + 1] = rk[i - 15] ^ t1;
        rk[i + 2] = rk[i - 14] ^ t2;
        rk[i + 3] = rk[i - 13] ^ t3;
    end
    for (int i = 0; i < 16; i++) begin
        st[i] = plain.bytes[i] ^ rk[i];
    end
    for (int r = 1; r <= aes_types_pkg::round_count; r++) begin
        // Column c of row k comes from column c + k
        for (int c = 0; c < 4; c++) begin
            for (int k = 0; k < 4; k++) begin
                tmp[4 * c + k] = sbox_table[st[4 * ((c + k) % 4) + k]];
            end
        end
        for (int c = 0; c < 4; c++) begin
            t0 = tmp[4 * c];
            t1 = tmp[4 * c + 1];
            t2 = tmp[4 * c + 2];
            t3 = tmp[4 * c + 3];
            if (r == aes_types_pkg::round_count) begin
                st[4 * c] = t0;
                st[4 * c + 1] = t1;
                st[4 * c + 2] = t2;
                st[4 * c + 3] = t3;
            end else begin
                st[4 * c] = field_mul(t0, 8'h02) ^ field_mul(t1, 8'h03) ^ t2 ^ t3;
                st[4 * c + 1] = t0 ^ field_mul(t1, 8'h02) ^ field_mul(t2, 8'h03) ^ t3;
                st[4 * c + 2] = t0 ^ t1 ^ field_mul(t2, 8'h02) ^ field_mul(t3, 8'h03);
                st[4 * c + 3] = field_mul(t0, 8'h03) ^ t1 ^ t2 ^ field_mul(t3, 8'h02);
            end
        end
        for (int i = 0; i < 16; i++) begin
            st[i] = st[i] ^ rk[16 * r + i];
        end
    end
    for (int i = 0; i < 16; i++) begin
        result.bytes[i] = st[i];
    end
    return result;
endfunction

`endif

// ==== tb_aes_encrypt.sv ====
`default_nettype none

module tb_aes_encrypt;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int random_blocks = 200;
    localparam int block_total = random_blocks + 1;
    localparam int cycle_limit = 20 * block_total + 100;
    localparam int latency = aes_types_pkg::stage_count;

    logic clk;
    logic reset;
    logic in_valid;
    aes_types_pkg::aes_block_u block_in;
    aes_types_pkg::aes_block_u key;
    aes_types_pkg::aes_block_u block_out;
    logic busy;
    logic out_valid;

    logic [31:0] lfsr_state;
    aes_types_pkg::aes_block_u last_result;
    int cycle_count;

    `include "aes_ref_model.svh"

    aes_encrypt u_dut (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .block_in  (block_in),
        .key       (key),
        .block_out (block_out),
        .busy      (busy),
        .out_valid (out_valid)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < cycle_limit) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout after %0d cycles, the test did not complete", cycle_count);
        $display("Finished with errors");
        $fatal(1, "run stopped by the cycle limit");
    end

    //////////////////////////////
    // Checks
    //////////////////////////////

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("Finished with errors");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_block(
        input string what,
        input aes_types_pkg::aes_block_u got,
        input aes_types_pkg::aes_block_u expected
    );
        if (got !== expected) begin
            stop_on_error($sformatf("mismatch at %0t ns: %s expected %h got %h",
                                    $time, what, expected, got));
        end
    endtask

    task automatic check_bit(input string what, input logic got, input logic expected);
        if (got !== expected) begin
            stop_on_error($sformatf("mismatch at %0t ns: %s expected %b got %b",
                                    $time, what, expected, got));
        end
    endtask

    //////////////////////////////
    // Stimulus
    //////////////////////////////

    task automatic random_bits(input int count, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < count; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            value[i] = lfsr_state[0];
        end
    endtask

    task automatic random_block(output aes_types_pkg::aes_block_u value);
        logic [31:0] word;
        for (int w = 0; w < aes_types_pkg::word_count; w++) begin
            random_bits(32, word);
            value.words[w] = word;
        end
    endtask

    task automatic idle_cycles(input int count);
        for (int i = 0; i < count; i++) begin
            @(negedge clk);
            check_bit("busy while idle", busy, 1'b0);
            check_bit("out_valid while idle", out_valid, 1'b0);
            check_block("block_out held while idle", block_out, last_result);
        end
    endtask

    // Starts just after a falling edge with the DUT idle
    task automatic run_block(
        input aes_types_pkg::aes_block_u plain,
        input aes_types_pkg::aes_block_u cipher_key,
        input aes_types_pkg::aes_block_u expected,
        input bit noisy
    );
        aes_types_pkg::aes_block_u junk;
        logic [31:0] pick;
        in_valid = 1'b1;
        block_in = plain;
        key = cipher_key;
        for (int step = 1; step <= latency + 1; step++) begin
            @(negedge clk);
            in_valid = 1'b0;
            // Requests while busy must be dropped
            if (noisy && step <= latency) begin
                random_bits(1, pick);
                random_block(junk);
                block_in = junk;
                random_block(junk);
                key = junk;
                in_valid = pick[0];
            end
            if (step <= latency) begin
                check_bit("busy while rounds run", busy, 1'b1);
                check_bit("out_valid before result", out_valid, 1'b0);
                check_block("block_out held from last result", block_out, last_result);
            end else begin
                check_bit("out_valid at result", out_valid, 1'b1);
                check_bit("busy at result", busy, 1'b0);
                check_block("ciphertext", block_out, expected);
            end
        end
        last_result = expected;
    endtask

    //////////////////////////////
    // Test sequence
    //////////////////////////////

    initial begin
        aes_types_pkg::aes_block_u plain;
        aes_types_pkg::aes_block_u cipher_key;
        aes_types_pkg::aes_block_u known_plain;
        aes_types_pkg::aes_block_u known_key;
        aes_types_pkg::aes_block_u known_cipher;
        logic [31:0] pick;
        logic [31:0] idle;
        reset = 1'b1;
        in_valid = 1'b0;
        block_in = '0;
        key = '0;
        lfsr_state = 32'd36;
        last_result = '0;
        build_sbox_table();

        // Three edges in reset, then release
        idle_cycles(3);
        reset = 1'b0;
        idle_cycles(2);

        known_plain = 128'h00112233445566778899aabbccddeeff;
        known_key = 128'h000102030405060708090a0b0c0d0e0f;
        known_cipher = 128'h69c4e0d86a7b0430d8cdb78070b4c55a;
        check_block("model on known vector", encrypt_model(known_plain, known_key),
                    known_cipher);
        run_block(known_plain, known_key, known_cipher, 1'b0);
        idle_cycles(3);

        for (int n = 0; n < random_blocks; n++) begin
            random_block(plain);
            random_block(cipher_key);
            random_bits(1, pick);
            run_block(plain, cipher_key, encrypt_model(plain, cipher_key), pick[0]);
            random_bits(2, idle);
            idle_cycles(int'(idle) + 1);
        end

        $display("Finished with no errors");
        $finish;
    end

endmodule

`default_nettype wire

// ==== aes_encrypt.sv ====
`default_nettype none

module aes_encrypt (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      in_valid,
    input  aes_types_pkg::aes_block_u block_in,
    input  aes_types_pkg::aes_block_u key,
    output aes_types_pkg::aes_block_u block_out,
    output logic                      busy,
    output logic                      out_valid
);

    localparam int stages = aes_types_pkg::stage_count;

    logic [stages-1:0] stage_enable;
    logic accept;

    aes_types_pkg::aes_block_u state_reg;
    aes_types_pkg::aes_block_u key_reg;
    aes_types_pkg::stage_bus_t stage_bus [0:stages];

    aes_stage_ctrl u_ctrl (
        .clk          (clk),
        .reset        (reset),
        .in_valid     (in_valid),
        .stage_enable (stage_enable),
        .busy         (busy),
        .out_valid    (out_valid)
    );

    //////////////////////////////
    // Input capture
    //////////////////////////////

    // Same edge as the first enable
    assign accept = in_valid && !busy;

    always_ff @(posedge clk) begin
        if (accept) begin
            state_reg <= block_in;
            key_reg   <= key;
        end
    end

    // Initial AddRoundKey
    assign stage_bus[0].state = state_reg ^ key_reg;
    assign stage_bus[0].round_key = key_reg;

    //////////////////////////////
    // Round stages
    //////////////////////////////

    for (genvar s = 0; s < stages; s++) begin : g_stage
        aes_pipe_stage #(
            .first_round (s * aes_types_pkg::rounds_per_stage + 1)
        ) u_stage (
            .clk       (clk),
            .reset     (reset),
            .enable    (stage_enable[s]),
            .stage_in  (stage_bus[s]),
            .stage_out (stage_bus[s+1])
        );
    end

    assign block_out = stage_bus[stages].state;

endmodule

`default_nettype wire

// ==== aes_stage_ctrl.sv ====
`default_nettype none

module aes_stage_ctrl (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic                                  in_valid,
    output logic [aes_types_pkg::stage_count-1:0] stage_enable,
    output logic                                  busy,
    output logic                                  out_valid
);

    localparam int last = aes_types_pkg::stage_count - 1;

    logic accept;

    // New block only when idle
    assign accept = in_valid && !busy;

    // One token walks through the enables
    always_ff @(posedge clk) begin
        if (reset) begin
            stage_enable <= '0;
        end else begin
            stage_enable <= {stage_enable[last-1:0], accept};
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            busy      <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            out_valid <= stage_enable[last];
            if (accept) begin
                busy <= 1'b1;
            end else if (stage_enable[last]) begin
                busy <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== aes_pipe_stage.sv ====
`default_nettype none

module aes_pipe_stage #(
    parameter int first_round = 1
) (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      enable,
    input  aes_types_pkg::stage_bus_t stage_in,
    output aes_types_pkg::stage_bus_t stage_out
);

    localparam int second_round = first_round + aes_types_pkg::rounds_per_stage - 1;

    aes_types_pkg::stage_bus_t mid;
    aes_types_pkg::stage_bus_t result;

    aes_round #(
        .round_index (first_round),
        .final_round (1'b0)
    ) u_round_first (
        .round_in  (stage_in),
        .round_out (mid)
    );

    aes_round #(
        .round_index (second_round),
        .final_round (second_round == aes_types_pkg::round_count)
    ) u_round_second (
        .round_in  (mid),
        .round_out (result)
    );

    //////////////////////////////
    // Stage register
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            stage_out <= '0;
        end else if (enable) begin
            stage_out <= result;
        end
    end

endmodule

`default_nettype wire

// ==== aes_round.sv ====
`default_nettype none

module aes_round #(
    parameter int round_index = 1,
    parameter bit final_round = 1'b0
) (
    input  aes_types_pkg::stage_bus_t round_in,
    output aes_types_pkg::stage_bus_t round_out
);

    aes_types_pkg::aes_block_u next_key;
    aes_types_pkg::aes_block_u sub_bytes;
    aes_types_pkg::aes_block_u shifted;
    aes_types_pkg::aes_block_u mixed;

    aes_key_expand #(
        .round_index(round_index)
    ) u_key_expand (
        .key      (round_in.round_key),
        .next_key (next_key)
    );

    always_comb begin
        for (int i = 0; i < aes_types_pkg::byte_count; i++) begin
            sub_bytes.bytes[i] = aes_math_pkg::sbox(round_in.state.bytes[i]);
        end
    end

    assign shifted = aes_math_pkg::shift_rows(sub_bytes);

    // Last round skips MixColumns
    if (final_round) begin : g_final
        assign mixed = shifted;
    end else begin : g_mix
        always_comb begin
            for (int c = 0; c < aes_types_pkg::word_count; c++) begin
                mixed.words[c] = aes_math_pkg::mix_column(shifted.words[c]);
            end
        end
    end

    assign round_out.state = mixed ^ next_key;
    assign round_out.round_key = next_key;

endmodule

`default_nettype wire

// ==== aes_key_expand.sv ====
`default_nettype none

module aes_key_expand #(
    parameter int round_index = 1
) (
    input  aes_types_pkg::aes_block_u key,
    output aes_types_pkg::aes_block_u next_key
);

    aes_types_pkg::aes_word_t last_word;
    aes_types_pkg::aes_word_t rotated;
    aes_types_pkg::aes_word_t temp;

    assign last_word = key.words[aes_types_pkg::word_count-1];
    assign rotated = {last_word[23:0], last_word[31:24]};

    // RotWord, SubWord, then Rcon
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            temp[8*i +: 8] = aes_math_pkg::sbox(rotated[8*i +: 8]);
        end
        temp = temp ^ aes_math_pkg::round_constant(round_index);
    end

    always_comb begin
        aes_types_pkg::aes_word_t acc;
        acc = temp;
        for (int w = 0; w < aes_types_pkg::word_count; w++) begin
            acc = acc ^ key.words[w];
            next_key.words[w] = acc;
        end
    end

endmodule

`default_nettype wire

// ==== aes_math_pkg.sv ====
`default_nettype none

package aes_math_pkg;

    //////////////////////////////
    // GF(2^8) arithmetic
    //////////////////////////////

    // Reduction by x^8 + x^4 + x^3 + x + 1
    function automatic aes_types_pkg::aes_byte_t gf_xtime(input aes_types_pkg::aes_byte_t b);
        return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
    endfunction

    function automatic aes_types_pkg::aes_byte_t gf_mul(
        input aes_types_pkg::aes_byte_t a,
        input aes_types_pkg::aes_byte_t b
    );
        aes_types_pkg::aes_byte_t acc;
        aes_types_pkg::aes_byte_t shifted;
        acc = 8'h00;
        shifted = a;
        for (int i = 0; i < 8; i++) begin
            if (b[i]) begin
                acc = acc ^ shifted;
            end
            shifted = gf_xtime(shifted);
        end
        return acc;
    endfunction

    // x^254 as x^2 * x^4 * ... * x^128, zero stays zero
    function automatic aes_types_pkg::aes_byte_t gf_inverse(input aes_types_pkg::aes_byte_t b);
        aes_types_pkg::aes_byte_t result;
        aes_types_pkg::aes_byte_t power;
        result = 8'h01;
        power = b;
        for (int i = 1; i < 8; i++) begin
            power = gf_mul(power, power);
            result = gf_mul(result, power);
        end
        return result;
    endfunction

    function automatic aes_types_pkg::aes_byte_t sbox(input aes_types_pkg::aes_byte_t b);
        aes_types_pkg::aes_byte_t inv;
        inv = gf_inverse(b);
        return inv ^ {inv[6:0], inv[7]} ^ {inv[5:0], inv[7:6]} ^
               {inv[4:0], inv[7:5]} ^ {inv[3:0], inv[7:4]} ^ 8'h63;
    endfunction

    // Round index 1 gives 01 in the top byte
    function automatic aes_types_pkg::aes_word_t round_constant(input int index);
        aes_types_pkg::aes_byte_t rc;
        rc = 8'h01;
        for (int i = 2; i <= aes_types_pkg::round_count; i++) begin
            if (i <= index) begin
                rc = gf_xtime(rc);
            end
        end
        return {rc, 24'h000000};
    endfunction

    //////////////////////////////
    // Block transforms
    //////////////////////////////

    // Row r moves left by r columns
    function automatic aes_types_pkg::aes_block_u shift_rows(input aes_types_pkg::aes_block_u s);
        aes_types_pkg::aes_block_u r;
        for (int c = 0; c < aes_types_pkg::word_count; c++) begin
            for (int row = 0; row < 4; row++) begin
                r.bytes[4 * c + row] = s.bytes[4 * ((c + row) % 4) + row];
            end
        end
        return r;
    endfunction

    function automatic aes_types_pkg::aes_word_t mix_column(input aes_types_pkg::aes_word_t w);
        aes_types_pkg::aes_byte_t a0;
        aes_types_pkg::aes_byte_t a1;
        aes_types_pkg::aes_byte_t a2;
        aes_types_pkg::aes_byte_t a3;
        {a0, a1, a2, a3} = w;
        return {gf_xtime(a0) ^ gf_xtime(a1) ^ a1 ^ a2 ^ a3,
                a0 ^ gf_xtime(a1) ^ gf_xtime(a2) ^ a2 ^ a3,
                a0 ^ a1 ^ gf_xtime(a2) ^ gf_xtime(a3) ^ a3,
                gf_xtime(a0) ^ a0 ^ a1 ^ a2 ^ gf_xtime(a3)};
    endfunction

endpackage

`default_nettype wire

// ==== aes_types_pkg.sv ====
`default_nettype none

package aes_types_pkg;

    //////////////////////////////
    // Sizes
    //////////////////////////////

    localparam int block_width = 128;
    localparam int byte_count = block_width / 8;
    localparam int word_count = block_width / 32;

    //////////////////////////////
    // Pipeline shape
    //////////////////////////////

    localparam int stage_count = 5;
    localparam int rounds_per_stage = 2;
    localparam int round_count = stage_count * rounds_per_stage;

    //////////////////////////////
    // Data types
    //////////////////////////////

    typedef logic [7:0] aes_byte_t;
    typedef logic [31:0] aes_word_t;

    // Byte 0 and word 0 sit at the most significant end
    typedef union packed {
        aes_byte_t [0:byte_count-1] bytes;
        aes_word_t [0:word_count-1] words;
    } aes_block_u;

    // State with its round key
    typedef struct packed {
        aes_block_u state;
        aes_block_u round_key;
    } stage_bus_t;

endpackage

`default_nettype wire
